// ==== design/nes_bus_pkg.sv ====
////////////////////////////////////////////////////////////
// NES bus definitions
// Widths of the host download bus and the cartridge
// memory bus, plus the memory slot timing constants
////////////////////////////////////////////////////////////

package nes_bus_pkg;

	// One download or memory data byte
	typedef logic [7:0] byte_t;

	// Cartridge memory address, PRG low and CHR high
	typedef logic [21:0] mem_addr_t;

	// Byte offset inside one host download
	typedef logic [24:0] host_addr_t;

	// Console clock enable phase, four per memory slot
	typedef logic [1:0] ce_phase_t;

	////////////////////////////////////////////////////////////
	// Timing
	////////////////////////////////////////////////////////////

	// Phase in which the console leaves the memory port free
	localparam ce_phase_t MEM_SLOT_PHASE = 2'd3;

	// Console reset hold after a download, in clocks
	localparam int RESET_HOLD_CYCLES = 255;

endpackage

// ==== design/ines_format_pkg.sv ====
////////////////////////////////////////////////////////////
// iNES file format definitions
// Header layout, magic bytes, ROM region bases, loader
// states and the mapper flags and cheat code types
////////////////////////////////////////////////////////////

package ines_format_pkg;

	// Whole 16 byte header, byte 0 in bits 7:0
	typedef logic [127:0] ines_header_t;

	// Decoded mapper flags word
	typedef logic [31:0] mapper_flags_t;

	// Bytes still to copy in one ROM region
	typedef logic [21:0] rom_count_t;

	// Clock bit, flags, address, compare, replace
	typedef logic [128:0] cheat_code_t;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_ERROR,
		LOAD_DONE
	} loader_state_t;

	////////////////////////////////////////////////////////////
	// Header layout
	////////////////////////////////////////////////////////////

	localparam int HEADER_BYTES  = 16;
	localparam int HDR_PRG_PAGES = 4;   // 16 KiB units
	localparam int HDR_CHR_PAGES = 5;   // 8 KiB units, 0 means CHR RAM
	localparam int HDR_FLAGS6    = 6;
	localparam int HDR_FLAGS7    = 7;
	localparam int TRAINER_BIT   = 2;   // Bit in flags 6

	// "NES" followed by MS-DOS end of file
	localparam logic [7:0] MAGIC_N   = 8'h4E;
	localparam logic [7:0] MAGIC_E   = 8'h45;
	localparam logic [7:0] MAGIC_S   = 8'h53;
	localparam logic [7:0] MAGIC_EOF = 8'h1A;

	////////////////////////////////////////////////////////////
	// Cartridge memory map
	////////////////////////////////////////////////////////////

	localparam logic [21:0] PRG_BASE = 22'h000000;
	localparam logic [21:0] CHR_BASE = 22'h200000;

	localparam int PRG_PAGE_SHIFT = 14;
	localparam int CHR_PAGE_SHIFT = 13;

endpackage

// ==== design/ines_loader.sv ====
////////////////////////////////////////////////////////////
// iNES loader
// Captures the header, checks it and copies the PRG and
// CHR ROM bytes to their cartridge memory addresses
////////////////////////////////////////////////////////////

module ines_loader (
	input  logic                          clk,
	input  logic                          reset_nes,
	input  logic                          rom_download,
	input  logic                          rom_strobe,
	input  nes_bus_pkg::byte_t            rom_byte,
	output nes_bus_pkg::mem_addr_t        load_addr,
	output nes_bus_pkg::byte_t            load_data,
	output logic                          load_write,
	output logic                          load_busy,
	output logic                          load_done,
	output logic                          load_error,
	output ines_format_pkg::ines_header_t header
);

	ines_format_pkg::loader_state_t state;
	ines_format_pkg::rom_count_t    bytes_left;
	ines_format_pkg::rom_count_t    prg_bytes;
	ines_format_pkg::rom_count_t    chr_bytes;
	nes_bus_pkg::byte_t             prg_pages;
	nes_bus_pkg::byte_t             chr_pages;
	nes_bus_pkg::byte_t             flags6;
	logic [3:0]                     hdr_ctr;
	logic                           download_q;
	logic                           take;
	logic                           copying;
	logic                           header_ok;
	logic                           last_hdr_byte;

	assign prg_pages = header[ines_format_pkg::HDR_PRG_PAGES*8 +: 8];
	assign chr_pages = header[ines_format_pkg::HDR_CHR_PAGES*8 +: 8];
	assign flags6    = header[ines_format_pkg::HDR_FLAGS6*8 +: 8];

	assign prg_bytes = ines_format_pkg::rom_count_t'(prg_pages) << ines_format_pkg::PRG_PAGE_SHIFT;
	assign chr_bytes = ines_format_pkg::rom_count_t'(chr_pages) << ines_format_pkg::CHR_PAGE_SHIFT;

	// Bytes 0 to 6 are already stored when byte 15 arrives
	assign header_ok = (header[7:0]   == ines_format_pkg::MAGIC_N) &&
	                   (header[15:8]  == ines_format_pkg::MAGIC_E) &&
	                   (header[23:16] == ines_format_pkg::MAGIC_S) &&
	                   (header[31:24] == ines_format_pkg::MAGIC_EOF) &&
	                   !flags6[ines_format_pkg::TRAINER_BIT];

	assign last_hdr_byte = (hdr_ctr == 4'(ines_format_pkg::HEADER_BYTES - 1));

	assign take    = rom_strobe && rom_download;
	assign copying = (state == ines_format_pkg::LOAD_PRG) || (state == ines_format_pkg::LOAD_CHR);

	// Write request goes out in the strobe cycle itself
	assign load_write = take && copying && (bytes_left != '0);
	assign load_data  = rom_byte;

	// Header store
	always_ff @(posedge clk) begin
		if (take && state == ines_format_pkg::LOAD_HEADER)
			header[{hdr_ctr, 3'b000} +: 8] <= rom_byte;
	end

	////////////////////////////////////////////////////////////
	// Load FSM
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state      <= ines_format_pkg::LOAD_HEADER;
			hdr_ctr    <= '0;
			download_q <= 1'b0;
			load_busy  <= 1'b0;
			load_done  <= 1'b0;
			load_error <= 1'b0;
		end else begin
			download_q <= rom_download;
			if (rom_download && !download_q) begin
				// New file, start over
				state      <= ines_format_pkg::LOAD_HEADER;
				hdr_ctr    <= '0;
				load_busy  <= 1'b0;
				load_done  <= 1'b0;
				load_error <= 1'b0;
			end else if (take) begin
				case (state)
					ines_format_pkg::LOAD_HEADER: begin
						hdr_ctr <= hdr_ctr + 4'd1;
						if (last_hdr_byte) begin
							if (!header_ok) begin
								state      <= ines_format_pkg::LOAD_ERROR;
								load_done  <= 1'b1;
								load_error <= 1'b1;
							end else if (prg_pages != '0) begin
								state      <= ines_format_pkg::LOAD_PRG;
								load_addr  <= ines_format_pkg::PRG_BASE;
								bytes_left <= prg_bytes;
								load_busy  <= 1'b1;
							end else if (chr_pages != '0) begin
								state      <= ines_format_pkg::LOAD_CHR;
								load_addr  <= ines_format_pkg::CHR_BASE;
								bytes_left <= chr_bytes;
								load_busy  <= 1'b1;
							end else begin
								state     <= ines_format_pkg::LOAD_DONE;  // Nothing to copy
								load_done <= 1'b1;
							end
						end
					end
					ines_format_pkg::LOAD_PRG, ines_format_pkg::LOAD_CHR: begin
						load_addr  <= load_addr + 22'd1;
						bytes_left <= bytes_left - 22'd1;
						if (bytes_left == 22'd1) begin
							if (state == ines_format_pkg::LOAD_PRG && chr_pages != '0) begin
								state      <= ines_format_pkg::LOAD_CHR;
								load_addr  <= ines_format_pkg::CHR_BASE;
								bytes_left <= chr_bytes;
							end else begin
								state     <= ines_format_pkg::LOAD_DONE;
								load_busy <= 1'b0;
								load_done <= 1'b1;
							end
						end
					end
					default: begin
						// Done or error, trailing bytes are dropped
					end
				endcase
			end
		end
	end

endmodule

// ==== design/mapper_flags_decoder.sv ====
////////////////////////////////////////////////////////////
// Mapper flags decoder
// Builds the 32-bit flags word from the iNES header and
// latches it when a load ends without error
////////////////////////////////////////////////////////////

module mapper_flags_decoder (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  ines_format_pkg::ines_header_t  header,
	input  logic                           invert_mirroring,
	input  logic                           load_done,
	input  logic                           load_error,
	output ines_format_pkg::mapper_flags_t mapper_flags
);

	// Smallest n with pages <= 2**n, saturating at 7
	function automatic logic [2:0] size_code(input nes_bus_pkg::byte_t pages);
		logic [2:0] code;
		code = 3'd7;
		for (int n = 6; n >= 0; n--) begin
			if (pages <= (9'd1 << n))
				code = 3'(n);
		end
		return code;
	endfunction

	nes_bus_pkg::byte_t prg_pages;
	nes_bus_pkg::byte_t chr_pages;
	nes_bus_pkg::byte_t flags6;
	nes_bus_pkg::byte_t flags7;
	nes_bus_pkg::byte_t nes20_mapper;
	logic [3:0]         prg_ram_shift;
	logic               is_nes20;
	logic               is_dirty;
	logic               piano;
	logic               done_q;
	ines_format_pkg::mapper_flags_t flags;

	assign prg_pages = header[ines_format_pkg::HDR_PRG_PAGES*8 +: 8];
	assign chr_pages = header[ines_format_pkg::HDR_CHR_PAGES*8 +: 8];
	assign flags6    = header[ines_format_pkg::HDR_FLAGS6*8 +: 8];
	assign flags7    = header[ines_format_pkg::HDR_FLAGS7*8 +: 8];

	assign is_nes20 = (flags7[3:2] == 2'b10);
	// Old dumps often carry junk in bytes 9 to 15
	assign is_dirty = !is_nes20 && ((header[79:73] != '0) || (header[127:80] != '0));

	assign nes20_mapper  = is_nes20 ? header[71:64] : 8'h00;   // Byte 8
	assign prg_ram_shift = is_nes20 ? header[83:80] : 4'h0;    // Byte 10 low nibble
	assign piano         = is_nes20 && (header[125:120] == 6'h19);

	assign flags = {1'b0, piano, prg_ram_shift, flags6[1], nes20_mapper,
	                flags6[3], (chr_pages == '0), flags6[0] ^ invert_mirroring,
	                size_code(chr_pages), size_code(prg_pages),
	                is_dirty ? 4'h0 : flags7[7:4], flags6[7:4]};

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			done_q       <= 1'b0;
			mapper_flags <= '0;
		end else begin
			done_q <= load_done;
			if (load_done && !done_q && !load_error)
				mapper_flags <= flags;   // Rejected files keep old flags
		end
	end

endmodule

// ==== design/cheat_code_assembler.sv ====
////////////////////////////////////////////////////////////
// Cheat code assembler
// Collects 16 download bytes into one cheat code and
// strobes it in with the last byte
////////////////////////////////////////////////////////////

module cheat_code_assembler (
	input  logic                         clk,
	input  logic                         reset_nes,
	input  logic                         cheat_download,
	input  logic                         cheat_strobe,
	input  nes_bus_pkg::byte_t           cheat_byte,
	input  nes_bus_pkg::host_addr_t      cheat_addr,
	output ines_format_pkg::cheat_code_t cheat_code,
	output logic                         cheat_valid
);

	logic [127:0] fields;
	logic [3:0]   idx;
	logic         take;

	assign idx  = cheat_addr[3:0];
	assign take = cheat_download && cheat_strobe;

	// Bit 128 is the load strobe
	assign cheat_code = {cheat_valid, fields};

	// Field order flags, address, compare, replace from the top.
	// Inside a field the first byte lands lowest
	always_ff @(posedge clk) begin
		if (take)
			fields[{~idx[3:2], idx[1:0], 3'b000} +: 8] <= cheat_byte;
	end

	always_ff @(posedge clk) begin
		if (reset_nes)
			cheat_valid <= 1'b0;
		else
			cheat_valid <= take && (idx == 4'd15);
	end

endmodule

// ==== design/write_pacer.sv ====
////////////////////////////////////////////////////////////
// Write pacer
// Holds each loader write until the console memory slot
// and stalls the host download meanwhile
////////////////////////////////////////////////////////////

module write_pacer (
	input  logic                   clk,
	input  logic                   reset_nes,
	input  logic                   load_write,
	input  nes_bus_pkg::mem_addr_t load_addr,
	input  nes_bus_pkg::byte_t     load_data,
	output nes_bus_pkg::mem_addr_t mem_addr,
	output nes_bus_pkg::byte_t     mem_data,
	output logic                   mem_write,
	output logic                   download_wait
);

	nes_bus_pkg::ce_phase_t ce_phase;
	logic                   pending;
	logic                   slot;

	assign slot      = (ce_phase == nes_bus_pkg::MEM_SLOT_PHASE);
	assign mem_write = pending && slot;

	// Captured write
	always_ff @(posedge clk) begin
		if (load_write) begin
			mem_addr <= load_addr;
			mem_data <= load_data;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			ce_phase      <= '0;
			pending       <= 1'b0;
			download_wait <= 1'b0;
		end else begin
			ce_phase <= ce_phase + 2'd1;   // Free running
			if (slot) begin
				if (pending)
					pending <= 1'b0;
				else if (download_wait)
					download_wait <= 1'b0;   // One slot after the write
			end
			if (load_write) begin
				pending       <= 1'b1;
				download_wait <= 1'b1;
			end
		end
	end

endmodule

// ==== design/console_reset_sequencer.sv ====
////////////////////////////////////////////////////////////
// Console reset sequencer
// Keeps the console in reset until a ROM is loaded
////////////////////////////////////////////////////////////

module console_reset_sequencer (
	input  logic clk,
	input  logic reset_nes,
	input  logic rom_download,
	input  logic load_busy,
	input  logic load_error,
	output logic console_reset
);

	logic       init_done;    // Set by the first download
	logic [7:0] hold_cnt;

	assign console_reset = !init_done || rom_download || (hold_cnt != '0) || load_error;

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			init_done <= 1'b0;
			hold_cnt  <= '0;
		end else begin
			if (rom_download) begin
				init_done <= 1'b1;
				hold_cnt  <= 8'(nes_bus_pkg::RESET_HOLD_CYCLES);
			end else if (!load_busy && hold_cnt != '0) begin
				hold_cnt <= hold_cnt - 8'd1;   // Waits for the loader to finish
			end
		end
	end

endmodule

// ==== design/cart_loader_top.sv ====
////////////////////////////////////////////////////////////
// Cartridge loader top level
// Host ROM and cheat downloads in, paced memory writes,
// mapper flags and console reset out
////////////////////////////////////////////////////////////

module cart_loader_top (
	input  logic                           clk,
	input  logic                           reset_nes,
	input  logic                           rom_download,
	input  logic                           rom_strobe,
	input  nes_bus_pkg::byte_t             rom_byte,
	input  logic                           cheat_download,
	input  logic                           cheat_strobe,
	input  nes_bus_pkg::byte_t             cheat_byte,
	input  nes_bus_pkg::host_addr_t        cheat_addr,
	input  logic                           invert_mirroring,
	output nes_bus_pkg::mem_addr_t         mem_addr,
	output nes_bus_pkg::byte_t             mem_data,
	output logic                           mem_write,
	output logic                           download_wait,
	output ines_format_pkg::mapper_flags_t mapper_flags,
	output ines_format_pkg::cheat_code_t   cheat_code,
	output logic                           cheat_valid,
	output logic                           console_reset,
	output logic                           load_done,
	output logic                           load_error
);

	nes_bus_pkg::mem_addr_t        load_addr;
	nes_bus_pkg::byte_t            load_data;
	logic                          load_write;
	logic                          load_busy;
	ines_format_pkg::ines_header_t header;

	ines_loader u_loader (
		.clk          (clk),
		.reset_nes    (reset_nes),
		.rom_download (rom_download),
		.rom_strobe   (rom_strobe),
		.rom_byte     (rom_byte),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.load_write   (load_write),
		.load_busy    (load_busy),
		.load_done    (load_done),
		.load_error   (load_error),
		.header       (header)
	);

	mapper_flags_decoder u_flags (
		.clk              (clk),
		.reset_nes        (reset_nes),
		.header           (header),
		.invert_mirroring (invert_mirroring),
		.load_done        (load_done),
		.load_error       (load_error),
		.mapper_flags     (mapper_flags)
	);

	write_pacer u_pacer (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.load_write    (load_write),
		.load_addr     (load_addr),
		.load_data     (load_data),
		.mem_addr      (mem_addr),
		.mem_data      (mem_data),
		.mem_write     (mem_write),
		.download_wait (download_wait)
	);

	cheat_code_assembler u_cheat (
		.clk            (clk),
		.reset_nes      (reset_nes),
		.cheat_download (cheat_download),
		.cheat_strobe   (cheat_strobe),
		.cheat_byte     (cheat_byte),
		.cheat_addr     (cheat_addr),
		.cheat_code     (cheat_code),
		.cheat_valid    (cheat_valid)
	);

	console_reset_sequencer u_reset (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.rom_download  (rom_download),
		.load_busy     (load_busy),
		.load_error    (load_error),
		.console_reset (console_reset)
	);

endmodule

// ==== verification/cart_loader_chk.sv ====
////////////////////////////////////////////////////////////
// Memory write checker
// Bound into the write pacer, watches slot timing and the
// host download stall
////////////////////////////////////////////////////////////

module cart_loader_chk (
	input logic                   clk,
	input logic                   reset_nes,
	input logic                   mem_write,
	input logic                   load_write,
	input logic                   download_wait,
	input nes_bus_pkg::ce_phase_t ce_phase
);

	// A write lasts one clock
	single_cycle_write: assert property (
		@(posedge clk) disable iff (reset_nes) mem_write |=> !mem_write
	) else $error("mem_write held for more than one cycle");

	slot_aligned_write: assert property (
		@(posedge clk) disable iff (reset_nes)
		mem_write |-> (ce_phase == nes_bus_pkg::MEM_SLOT_PHASE)
	) else $error("mem_write outside the memory slot phase");

	// Host has to wait for the previous write
	no_write_while_stalled: assert property (
		@(posedge clk) disable iff (reset_nes) load_write |-> !download_wait
	) else $error("load_write while download_wait is high");

endmodule

// ==== verification/cart_loader_tb.sv ====
////////////////////////////////////////////////////////////
// Cartridge loader testbench
// Table of iNES headers downloaded with xorshift ROM data,
// memory writes, flags, console reset and a cheat code
////////////////////////////////////////////////////////////

module cart_loader_tb;

	localparam int          ROWS = 5;
	localparam logic [31:0] SEED = 32'h19e1;

	logic                           clk;
	logic                           reset_nes;
	logic                           rom_download;
	logic                           rom_strobe;
	nes_bus_pkg::byte_t             rom_byte;
	logic                           cheat_download;
	logic                           cheat_strobe;
	nes_bus_pkg::byte_t             cheat_byte;
	nes_bus_pkg::host_addr_t        cheat_addr;
	logic                           invert_mirroring;
	nes_bus_pkg::mem_addr_t         mem_addr;
	nes_bus_pkg::byte_t             mem_data;
	logic                           mem_write;
	logic                           download_wait;
	ines_format_pkg::mapper_flags_t mapper_flags;
	ines_format_pkg::cheat_code_t   cheat_code;
	logic                           cheat_valid;
	logic                           console_reset;
	logic                           load_done;
	logic                           load_error;

	// Stimulus table, one row per ROM download
	ines_format_pkg::ines_header_t  hdr_tab   [ROWS];
	logic                           inv_tab   [ROWS];
	ines_format_pkg::mapper_flags_t flags_tab [ROWS];
	logic                           err_tab   [ROWS];

	int                             error_count;
	int                             check_count;
	int                             cycle_count;
	int                             cycle_limit;
	int                             prg_size;
	int                             chr_size;
	int                             writes_seen;
	int                             writes_expected;
	int                             cheat_pulses;
	logic [31:0]                    drv_state;     // Driver side random stream
	logic [31:0]                    chk_state;     // Same stream, replayed by the monitor
	ines_format_pkg::cheat_code_t   cheat_seen;
	ines_format_pkg::mapper_flags_t good_flags;

	cart_loader_top DUT (.*);

	bind write_pacer cart_loader_chk u_chk (
		.clk           (clk),
		.reset_nes     (reset_nes),
		.mem_write     (mem_write),
		.load_write    (load_write),
		.download_wait (download_wait),
		.ce_phase      (ce_phase)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// Magic bytes first, then size, flag and tail bytes 8 to 15
	function automatic ines_format_pkg::ines_header_t ines_header(input logic [7:0] prg,
			input logic [7:0] chr, input logic [7:0] f6, input logic [7:0] f7,
			input logic [63:0] tail);
		return {tail, f7, f6, chr, prg, 8'h1A, 8'h53, 8'h45, 8'h4E};
	endfunction

	function automatic nes_bus_pkg::mem_addr_t expected_addr(input int idx);
		if (idx < prg_size)
			return ines_format_pkg::PRG_BASE + 22'(idx);
		return ines_format_pkg::CHR_BASE + 22'(idx - prg_size);   // CHR follows PRG
	endfunction

	task automatic check_value(input string name, input logic [128:0] actual,
			input logic [128:0] expected);
		check_count++;
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] t=%0t %s got %0h expected %0h", $time, name, actual, expected);
		end
	endtask

	task automatic send_rom_byte(input nes_bus_pkg::byte_t b);
		@(negedge clk);
		while (download_wait)
			@(negedge clk);
		@(posedge clk);
		rom_strobe <= 1'b1;
		rom_byte   <= b;
		@(posedge clk);
		rom_strobe <= 1'b0;
	endtask

	task automatic send_cheat_byte(input nes_bus_pkg::byte_t b, input int idx);
		@(posedge clk);
		cheat_strobe <= 1'b1;
		cheat_byte   <= b;
		cheat_addr   <= 25'(idx);
		@(posedge clk);
		cheat_strobe <= 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// One ROM download from the table
	////////////////////////////////////////////////////////////

	task automatic run_rom_row(input int r);
		ines_format_pkg::ines_header_t hdr;
		int                            hold;
		hdr             = hdr_tab[r];
		prg_size        = int'(hdr[39:32]) * 16384;
		chr_size        = int'(hdr[47:40]) * 8192;
		writes_seen     = 0;
		writes_expected = err_tab[r] ? 0 : prg_size + chr_size;
		@(posedge clk);
		invert_mirroring <= inv_tab[r];
		rom_download     <= 1'b1;
		for (int i = 0; i < 16; i++)
			send_rom_byte(hdr[i * 8 +: 8]);
		for (int i = 0; i < prg_size + chr_size; i++) begin
			if (err_tab[r]) begin
				send_rom_byte(8'(i));   // Body of a rejected file
			end else begin
				drv_state = xorshift(drv_state);
				send_rom_byte(drv_state[7:0]);
			end
		end
		@(negedge clk);
		while (!load_done || download_wait)   // Last write must retire too
			@(negedge clk);
		@(negedge clk);
		check_value("load_error", load_error, err_tab[r]);
		check_value("mem_write count", writes_seen, writes_expected);
		if (!err_tab[r])
			good_flags = flags_tab[r];
		check_value("mapper_flags", mapper_flags, good_flags);
		@(posedge clk);
		rom_download <= 1'b0;
		hold = 0;
		@(negedge clk);
		while (console_reset && hold < 1000) begin
			hold++;
			@(negedge clk);
		end
		if (err_tab[r])
			check_value("console_reset", console_reset, 1'b1);   // Held by the error
		else
			check_value("console_reset hold", hold, 255);
	endtask

	task automatic run_cheat_load();
		ines_format_pkg::cheat_code_t exp_code;
		nes_bus_pkg::byte_t           b;
		exp_code     = '0;
		cheat_pulses = 0;
		@(posedge clk);
		cheat_download <= 1'b1;
		for (int i = 0; i < 16; i++) begin
			drv_state = xorshift(drv_state);
			b = drv_state[7:0];
			exp_code[(3 - i / 4) * 32 + (i % 4) * 8 +: 8] = b;   // Low byte first in a field
			send_cheat_byte(b, i);
		end
		exp_code[128] = 1'b1;
		repeat (4) @(negedge clk);
		@(posedge clk);
		cheat_download <= 1'b0;
		check_value("cheat_valid pulses", cheat_pulses, 1);
		check_value("cheat_code", cheat_seen, exp_code);
	endtask

	// Memory write and strobe monitor
	always @(negedge clk) begin
		if (!reset_nes) begin
			if (mem_write) begin
				if (writes_seen < writes_expected) begin
					chk_state = xorshift(chk_state);
					check_value("mem_addr", mem_addr, expected_addr(writes_seen));
					check_value("mem_data", mem_data, chk_state[7:0]);
				end else begin
					$display("Unexpected mem_write at t=%0t to address %0h", $time, mem_addr);
					error_count++;
				end
				writes_seen++;
			end
			if (rom_download)
				check_value("console_reset", console_reset, 1'b1);
			if (cheat_valid) begin
				cheat_pulses++;
				cheat_seen = cheat_code;
			end
		end
	end

	// Watchdog
	initial begin
		cycle_count = 0;
		while (cycle_limit == 0 || cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the DUT stopped responding", cycle_count);
		$display("=== FAIL ===");
		$finish;
	end

	initial begin
		int total;
		reset_nes        = 1'b1;
		rom_download     = 1'b0;
		rom_strobe       = 1'b0;
		rom_byte         = '0;
		cheat_download   = 1'b0;
		cheat_strobe     = 1'b0;
		cheat_byte       = '0;
		cheat_addr       = '0;
		invert_mirroring = 1'b0;
		error_count      = 0;
		check_count      = 0;
		writes_seen      = 0;
		writes_expected  = 0;
		cheat_pulses     = 0;
		drv_state        = SEED;
		chk_state        = SEED;
		good_flags       = '0;

		// Plain iNES, mapper 1, one PRG and one CHR page, vertical mirroring
		hdr_tab[0]   = ines_header(8'd1, 8'd1, 8'h11, 8'h00, 64'h0);
		inv_tab[0]   = 1'b0;
		flags_tab[0] = 32'h0000_4001;
		err_tab[0]   = 1'b0;
		// Bad magic
		hdr_tab[1]        = ines_header(8'd1, 8'd1, 8'h21, 8'h00, 64'h0);
		hdr_tab[1][15:8]  = 8'h46;
		inv_tab[1]        = 1'b0;
		flags_tab[1]      = 32'h0;
		err_tab[1]        = 1'b1;
		// Junk in byte 12 drops the high mapper nibble; CHR RAM, mirroring flipped
		hdr_tab[2]   = ines_header(8'd2, 8'd0, 8'h20, 8'h30, 64'h0000_0044_0000_0000);
		inv_tab[2]   = 1'b1;
		flags_tab[2] = 32'h0000_C102;
		err_tab[2]   = 1'b0;
		// Trainer present
		hdr_tab[3]   = ines_header(8'd1, 8'd1, 8'h15, 8'h00, 64'h0);
		inv_tab[3]   = 1'b0;
		flags_tab[3] = 32'h0;
		err_tab[3]   = 1'b1;
		// NES 2.0, CHR only, four-screen, battery, piano
		hdr_tab[4]   = ines_header(8'd0, 8'd1, 8'hAA, 8'h18, 64'h1900_0000_0007_0012);
		inv_tab[4]   = 1'b0;
		flags_tab[4] = 32'h5E25_001A;
		err_tab[4]   = 1'b0;

		total = 16;   // Cheat record
		for (int r = 0; r < ROWS; r++)
			total += 16 + int'(hdr_tab[r][39:32]) * 16384 +
				int'(hdr_tab[r][47:40]) * 8192;
		cycle_limit = 5 * total * 4 + 2000;

		repeat (3) @(posedge clk);
		reset_nes <= 1'b0;
		@(negedge clk);
		check_value("mem_write", mem_write, 1'b0);
		check_value("download_wait", download_wait, 1'b0);
		check_value("cheat_valid", cheat_valid, 1'b0);
		check_value("load_done", load_done, 1'b0);
		check_value("load_error", load_error, 1'b0);
		repeat (10) @(negedge clk);
		check_value("console_reset", console_reset, 1'b1);   // No ROM yet

		for (int r = 0; r < ROWS; r++)
			run_rom_row(r);
		run_cheat_load();

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== cart_loader.f ====
design/nes_bus_pkg.sv
design/ines_format_pkg.sv
design/ines_loader.sv
design/mapper_flags_decoder.sv
design/cheat_code_assembler.sv
design/write_pacer.sv
design/console_reset_sequencer.sv
design/cart_loader_top.sv
verification/cart_loader_chk.sv
verification/cart_loader_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module cart_loader_tb \
	-f cart_loader.f -o cart_loader_sim

out=$(./obj_dir/cart_loader_sim)
echo "$out"

if echo "$out" | grep -qx "=== PASS ==="; then
	exit 0
fi
exit 1
